// ==== verilog/spio_link_test_pkg.sv ====
// Link-test shared definitions
// Link count, field widths, counter bank codes
// Vector typedefs and the checker state enum

package spio_link_test_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Links in the fabric
  localparam int num_links     = 16;

  // Frame fields
  localparam int pkt_data_bits = 16;
  localparam int seq_bits      = 3;

  // Counter port
  localparam int ctr_addr_bits = 6;
  localparam int ctr_data_bits = 32;

  // Address split, bank on top, link below
  localparam int link_sel_bits = 4;
  localparam int bank_sel_bits = ctr_addr_bits - link_sel_bits;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // One bit per link
  typedef logic [num_links-1:0]     link_vec_t;

  // Frame payload and wrapping tag
  typedef logic [pkt_data_bits-1:0] pkt_data_t;
  typedef logic [seq_bits-1:0]      seq_t;

  // Counter address and value
  typedef logic [ctr_addr_bits-1:0] ctr_addr_t;
  typedef logic [ctr_data_bits-1:0] ctr_data_t;

  // ----------------------------------------
  // Enums
  // ----------------------------------------

  // Bank codes in the upper address bits, code 3 unused
  typedef enum logic [bank_sel_bits-1:0] {
    bank_pkt_cnt = 2'd0,
    bank_flt_err = 2'd1,
    bank_frm_err = 2'd2
  } ctr_bank_t;

  // Holding register occupancy
  typedef enum logic {
    chk_empty = 1'b0,
    chk_full  = 1'b1
  } chk_state_t;

endpackage

// ==== verilog/spio_frame_checker.sv ====
// One-link frame checker
// Odd-parity and sequence-tag checks on each frame strobe
// One-entry packet holding register with valid/ready drain
// Registered flit-error and frame-error pulses

`timescale 1ns/1ps

module spio_frame_checker
  import spio_link_test_pkg::*;
(
  input  logic      CLK_IN,
  input  logic      RESET_IN,

  // Frame input, fields valid with frm_vld
  input  logic      frm_vld,
  input  pkt_data_t frm_data,
  input  logic      frm_par,
  input  seq_t      frm_seq,

  // Packet output
  input  logic      pkt_rdy,
  output logic      pkt_vld,
  output pkt_data_t pkt_data,

  // Error pulses, one cycle each
  output logic      flt_err,
  output logic      frm_err
);

  // ----------------------------------------
  // Internal signals
  // ----------------------------------------

  // Holding register state
  chk_state_t state;
  chk_state_t state_nxt;

  // Expected tag
  seq_t       exp_seq;
  seq_t       exp_seq_nxt;

  // Frame checks
  logic       par_ok;
  logic       seq_ok;

  // Holding register conditions
  logic       drain;
  logic       blocked;
  logic       load;

  // Error detection, registered below
  logic       flt_det;
  logic       frm_det;

  // ----------------------------------------
  // Frame checks
  // ----------------------------------------

  // Odd parity over payload plus parity bit
  assign par_ok  = ^{frm_data, frm_par};

  // Tag must match the expected one
  assign seq_ok  = (frm_seq == exp_seq);

  // Held packet leaves on this edge
  assign drain   = (state == chk_full) && pkt_rdy;

  // Register full and not draining
  assign blocked = (state == chk_full) && !pkt_rdy;

  // Good frame that fits, a drain on the same edge frees the slot
  assign load    = frm_vld && par_ok && seq_ok && !blocked;

  // Parity failure is a flit error
  assign flt_det = frm_vld && !par_ok;

  // Tag gap, or good frame with nowhere to go
  assign frm_det = frm_vld && par_ok && (!seq_ok || blocked);

  // ----------------------------------------
  // Expected tag
  // ----------------------------------------

  always_comb
  begin
    exp_seq_nxt = exp_seq;
    // Bad parity leaves the tag alone
    if (frm_vld && par_ok)
    begin
      if (seq_ok)
        // In order, advances even when the frame is dropped
        exp_seq_nxt = exp_seq + seq_t'(1);
      else
        // Gap, resync to the received tag
        exp_seq_nxt = frm_seq + seq_t'(1);
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      exp_seq <= '0;
    else
      exp_seq <= exp_seq_nxt;
  end

  // ----------------------------------------
  // Holding register
  // ----------------------------------------

  always_comb
  begin
    state_nxt = state;
    if (load)
      state_nxt = chk_full;
    else if (drain)
      state_nxt = chk_empty;
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      state <= chk_empty;
    else
      state <= state_nxt;
  end

  // Payload only, occupancy is tracked by state
  always_ff @(posedge CLK_IN)
  begin
    if (load)
      pkt_data <= frm_data;
  end

  assign pkt_vld = (state == chk_full);

  // ----------------------------------------
  // Error pulses
  // ----------------------------------------

  // High for the cycle after the offending frame
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      flt_err <= 1'b0;
      frm_err <= 1'b0;
    end
    else
    begin
      flt_err <= flt_det;
      frm_err <= frm_det;
    end
  end

endmodule

// ==== verilog/spio_packet_counter.sv ====
// Per-link packet, flit-error and frame-error counters
// Combinational readback selected by bank and link address

`timescale 1ns/1ps

module spio_packet_counter
  import spio_link_test_pkg::*;
(
  input  logic      CLK_IN,
  input  logic      RESET_IN,

  // Packet handshake, observed only
  input  link_vec_t pkt_vld,
  input  link_vec_t pkt_rdy,

  // Error pulses from the checkers
  input  link_vec_t flt_err,
  input  link_vec_t frm_err,

  // Readback port
  input  ctr_addr_t ctr_addr,
  output ctr_data_t ctr_data
);

  // ----------------------------------------
  // Counter storage
  // ----------------------------------------

  // Packets transferred
  ctr_data_t pkt_ctr [num_links];

  // Flit errors
  ctr_data_t fle_ctr [num_links];

  // Frame errors
  ctr_data_t fre_ctr [num_links];

  // Address fields
  logic [bank_sel_bits-1:0] bank_sel;
  logic [link_sel_bits-1:0] link_sel;

  // ----------------------------------------
  // Counters
  // ----------------------------------------

  // Three wrapping counters per link
  for (genvar i = 0; i < num_links; i++)
  begin : g_link

    // Count on valid and ready together
    always_ff @(posedge CLK_IN or posedge RESET_IN)
    begin
      if (RESET_IN)
        pkt_ctr[i] <= '0;
      else if (pkt_vld[i] && pkt_rdy[i])
        pkt_ctr[i] <= pkt_ctr[i] + ctr_data_t'(1);
    end

    // One per flit-error pulse
    always_ff @(posedge CLK_IN or posedge RESET_IN)
    begin
      if (RESET_IN)
        fle_ctr[i] <= '0;
      else if (flt_err[i])
        fle_ctr[i] <= fle_ctr[i] + ctr_data_t'(1);
    end

    // One per frame-error pulse
    always_ff @(posedge CLK_IN or posedge RESET_IN)
    begin
      if (RESET_IN)
        fre_ctr[i] <= '0;
      else if (frm_err[i])
        fre_ctr[i] <= fre_ctr[i] + ctr_data_t'(1);
    end

  end

  // ----------------------------------------
  // Readback
  // ----------------------------------------

  // Bank in the upper bits, link in the lower
  assign bank_sel = ctr_addr[ctr_addr_bits-1:link_sel_bits];
  assign link_sel = ctr_addr[link_sel_bits-1:0];

  always_comb
  begin
    case (ctr_bank_t'(bank_sel))
      bank_pkt_cnt: ctr_data = pkt_ctr[link_sel];
      bank_flt_err: ctr_data = fle_ctr[link_sel];
      bank_frm_err: ctr_data = fre_ctr[link_sel];
      // Unused bank code
      default:      ctr_data = '1;
    endcase
  end

endmodule

// ==== verilog/spio_link_test_top.sv ====
// Link-test top level
// One frame checker per link and a shared counter bank

`timescale 1ns/1ps

module spio_link_test_top
  import spio_link_test_pkg::*;
(
  input  logic                      CLK_IN,
  input  logic                      RESET_IN,

  // Frame inputs, indexed by link
  input  link_vec_t                 frm_vld,
  input  pkt_data_t [num_links-1:0] frm_data,
  input  link_vec_t                 frm_par,
  input  seq_t      [num_links-1:0] frm_seq,

  // Packet outputs
  input  link_vec_t                 pkt_rdy,
  output link_vec_t                 pkt_vld,
  output pkt_data_t [num_links-1:0] pkt_data,

  // Error pulses, also feed the counters
  output link_vec_t                 flt_err,
  output link_vec_t                 frm_err,

  // Counter readback
  input  ctr_addr_t                 ctr_addr,
  output ctr_data_t                 ctr_data
);

  // ----------------------------------------
  // Frame checkers
  // ----------------------------------------

  for (genvar i = 0; i < num_links; i++)
  begin : g_chk
    spio_frame_checker u_chk
    (
      .CLK_IN   (CLK_IN),
      .RESET_IN (RESET_IN),
      // Frame in
      .frm_vld  (frm_vld[i]),
      .frm_data (frm_data[i]),
      .frm_par  (frm_par[i]),
      .frm_seq  (frm_seq[i]),
      // Packet out
      .pkt_rdy  (pkt_rdy[i]),
      .pkt_vld  (pkt_vld[i]),
      .pkt_data (pkt_data[i]),
      // Errors
      .flt_err  (flt_err[i]),
      .frm_err  (frm_err[i])
    );
  end

  // ----------------------------------------
  // Counter bank
  // ----------------------------------------

  // Watches handshakes and error pulses of all links
  spio_packet_counter u_ctr
  (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_err  (flt_err),
    .frm_err  (frm_err),
    .ctr_addr (ctr_addr),
    .ctr_data (ctr_data)
  );

endmodule

// ==== test/spio_link_test_checker.sv ====
// Link-test reference model
// Compares packet outputs, error pulses and counter readback

`timescale 1ns/1ps

module spio_link_test_checker
  import spio_link_test_pkg::*;
(
  input  logic                      CLK_IN,
  input  logic                      RESET_IN,
  // DUT ports, observed only
  input  link_vec_t                 frm_vld,
  input  pkt_data_t [num_links-1:0] frm_data,
  input  link_vec_t                 frm_par,
  input  seq_t      [num_links-1:0] frm_seq,
  input  link_vec_t                 pkt_rdy,
  input  link_vec_t                 pkt_vld,
  input  pkt_data_t [num_links-1:0] pkt_data,
  input  link_vec_t                 flt_err,
  input  link_vec_t                 frm_err,
  input  ctr_addr_t                 ctr_addr,
  input  ctr_data_t                 ctr_data,
  // Test control from the stimulus side
  input  logic                      rd_en,
  input  logic [1:0]                row_kind,
  input  logic                      test_end,
  input  int                        test_num,
  input  logic                      report,
  output seq_t      [num_links-1:0] exp_tags,
  output int                        err_cnt
);

  // Expected payloads, counts per bank and link, pending pulses
  pkt_data_t  exp_q [num_links][$];
  ctr_data_t  cnt [3][num_links];
  link_vec_t  flt_exp;
  link_vec_t  frm_exp;
  int         checks;
  int         tests;
  int         test_errs;
  logic [1:0] verdict;
  ctr_data_t  exp_ctr;

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
    checks++;
    if (got !== want)
    begin
      err_cnt++;
      test_errs++;
      $display("FAILED %s: got %h, expected %h", name, got, want);
    end
  endtask

  // ----------------------------------------
  // Compare, then advance the model
  // ----------------------------------------

  always @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      for (int l = 0; l < num_links; l++)
      begin
        exp_q[l].delete();
        exp_tags[l] = '0;
        for (int b = 0; b < 3; b++)
          cnt[b][l] = '0;
      end
      flt_exp = '0;
      frm_exp = '0;
      checks = 0;
      tests = 0;
      test_errs = 0;
      err_cnt = 0;
    end
    else
    begin
      // Bank in addr[5:4], code 3 reads all ones
      if (rd_en)
      begin
        exp_ctr = (ctr_addr[5:4] == 2'd3) ? '1 : cnt[ctr_addr[5:4]][ctr_addr[3:0]];
        compare_value($sformatf("ctr_data[addr %h]", ctr_addr), ctr_data, exp_ctr);
      end
      for (int l = 0; l < num_links; l++)
      begin
        // Values before this edge
        compare_value($sformatf("pkt_vld[%0d]", l), pkt_vld[l], exp_q[l].size() != 0);
        if (exp_q[l].size() != 0)
          compare_value($sformatf("pkt_data[%0d]", l), pkt_data[l], exp_q[l][0]);
        compare_value($sformatf("flt_err[%0d]", l), flt_err[l], flt_exp[l]);
        compare_value($sformatf("frm_err[%0d]", l), frm_err[l], frm_exp[l]);
        // Pulses now high are counted on this edge
        if (flt_exp[l])
          cnt[bank_flt_err][l]++;
        if (frm_exp[l])
          cnt[bank_frm_err][l]++;
        // Frame fate: 0 accepted, 1 flit error, 2 frame error
        verdict = 2'd0;
        // Good parity has an odd count of ones
        if (frm_vld[l] && ($countones({frm_data[l], frm_par[l]}) % 2 == 0))
          verdict = 2'd1;
        else if (frm_vld[l] && frm_seq[l] != exp_tags[l])
        begin
          verdict = 2'd2;
          exp_tags[l] = frm_seq[l] + seq_t'(1);
        end
        else if (frm_vld[l])
        begin
          exp_tags[l] = exp_tags[l] + seq_t'(1);
          // Full and not draining
          if (exp_q[l].size() != 0 && !pkt_rdy[l])
            verdict = 2'd2;
        end
        if (exp_q[l].size() != 0 && pkt_rdy[l])
        begin
          void'(exp_q[l].pop_front());
          cnt[bank_pkt_cnt][l]++;
        end
        if (frm_vld[l] && verdict == 2'd0)
          exp_q[l].push_back(frm_data[l]);
        flt_exp[l] = frm_vld[l] && verdict == 2'd1;
        frm_exp[l] = frm_vld[l] && verdict == 2'd2;
        // Table outcome against the rules, code 3 is free
        if (frm_vld[l] && row_kind != 2'd3)
          compare_value($sformatf("frame outcome[%0d]", l), row_kind, verdict);
      end
      if (test_end)
      begin
        $display("test %0d done, %0d mismatches", test_num, test_errs);
        tests++;
        test_errs = 0;
      end
      if (report)
        $display("tests %0d, checks %0d, errors %0d", tests, checks, err_cnt);
    end
  end

endmodule

// ==== test/spio_link_test_asserts.sv ====
// Frame checker assertions
// Held packet stability, exclusive error pulses, idle after reset

`timescale 1ns/1ps

module spio_link_test_asserts
  import spio_link_test_pkg::*;
(
  input logic      CLK_IN,
  input logic      RESET_IN,
  input logic      pkt_rdy,
  input logic      pkt_vld,
  input pkt_data_t pkt_data,
  input logic      flt_err,
  input logic      frm_err
);

  // Failures on this link
  int fail_cnt = 0;

  // Held packet stays put until taken
  hold_stable: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    pkt_vld && !pkt_rdy |=> pkt_vld && $stable(pkt_data))
  else
  begin
    $error("held packet changed while pkt_rdy was low");
    fail_cnt++;
  end

  // At most one error kind per frame
  one_error: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    !(flt_err && frm_err))
  else
  begin
    $error("flt_err and frm_err high together");
    fail_cnt++;
  end

  // Holding register empty on the first edge out of reset
  idle_after_reset: assert property (@(posedge CLK_IN) $fell(RESET_IN) |-> !pkt_vld)
  else
  begin
    $error("pkt_vld high right after reset");
    fail_cnt++;
  end

endmodule

bind spio_frame_checker spio_link_test_asserts u_asserts (.*);

// ==== test/spio_link_test_tb.sv ====
// Link-test testbench
// Clock, reset, stimulus table, counter readback and final report

`timescale 1ns/1ps

module spio_link_test_tb;
  import spio_link_test_pkg::*;

  localparam int fixed_rows = 17;
  localparam int num_rows   = fixed_rows + 16;
  localparam int max_cycles = num_rows * 4 + 200;
  // Outcome codes, k_any left unchecked
  localparam int k_ok  = 0;
  localparam int k_flt = 1;
  localparam int k_frm = 2;
  localparam int k_any = 3;

  // Link, payload, parity good, tag offset, ready level, outcome
  typedef struct packed {
    logic [3:0] link;
    pkt_data_t  payload;
    logic       par_good;
    seq_t       offset;
    logic       rdy;
    logic [1:0] kind;
  } row_t;

  logic                      CLK_IN;
  logic                      RESET_IN;
  link_vec_t                 frm_vld;
  pkt_data_t [num_links-1:0] frm_data;
  link_vec_t                 frm_par;
  seq_t      [num_links-1:0] frm_seq;
  link_vec_t                 pkt_rdy;
  link_vec_t                 pkt_vld;
  pkt_data_t [num_links-1:0] pkt_data;
  link_vec_t                 flt_err;
  link_vec_t                 frm_err;
  ctr_addr_t                 ctr_addr;
  ctr_data_t                 ctr_data;
  logic                      rd_en;
  logic [1:0]                row_kind;
  logic                      test_end;
  int                        test_num;
  logic                      report;
  seq_t      [num_links-1:0] exp_tags;
  int                        err_cnt;
  int                        cycles = 0;
  row_t                      rows [num_rows];
  // Assertion failures per link
  int                        assert_fails [num_links];

  spio_link_test_top uut (.*);
  spio_link_test_checker u_check (.*);

  for (genvar g = 0; g < num_links; g++)
  begin : g_af
    assign assert_fails[g] = uut.g_chk[g].u_chk.u_asserts.fail_cnt;
  end

  function automatic int total_assert_fails();
    int sum;
    sum = 0;
    for (int i = 0; i < num_links; i++)
      sum += assert_fails[i];
    return sum;
  endfunction

  task automatic put_row(int i, int link, pkt_data_t payload, logic par_good, int offset,
                         logic rdy, int kind);
    rows[i] = {4'(link), payload, par_good, 3'(offset), rdy, 2'(kind)};
  endtask

  task automatic load_table();
    // In order, then parity, gaps, blocking
    put_row(0, 0, 16'h1234, 1, 0, 1, k_ok);
    put_row(1, 0, 16'h5678, 1, 0, 1, k_ok);
    put_row(2, 0, 16'h9abc, 1, 0, 1, k_ok);
    put_row(3, 3, 16'h0f0f, 1, 0, 1, k_ok);
    put_row(4, 1, 16'hdead, 0, 0, 1, k_flt);
    put_row(5, 1, 16'hbeef, 1, 0, 1, k_ok);
    put_row(6, 1, 16'h00ff, 0, 5, 1, k_flt);
    put_row(7, 2, 16'haaaa, 1, 0, 1, k_ok);
    put_row(8, 2, 16'hbbbb, 1, 2, 1, k_frm);
    put_row(9, 2, 16'hcccc, 1, 0, 1, k_ok);
    put_row(10, 5, 16'h1111, 1, 0, 0, k_ok);
    put_row(11, 5, 16'h2222, 1, 0, 0, k_frm);
    put_row(12, 5, 16'h3333, 1, 0, 1, k_ok);
    put_row(13, 5, 16'h4444, 1, 0, 1, k_ok);
    put_row(14, 9, 16'h5a5a, 1, 7, 0, k_frm);
    put_row(15, 15, 16'hc3c3, 1, 0, 0, k_ok);
    put_row(16, 15, 16'h7e7e, 0, 0, 0, k_flt);
    // Random links, payloads and ready levels
    for (int i = fixed_rows; i < num_rows; i++)
      put_row(i, $urandom % num_links, pkt_data_t'($urandom), 1, 0, 1'($urandom), k_any);
  endtask

  task automatic end_test(int n);
    @(negedge CLK_IN);
    test_num = n;
    test_end = 1'b1;
    @(negedge CLK_IN);
    test_end = 1'b0;
  endtask

  task automatic apply_row(int i);
    row_t r;
    r = rows[i];
    frm_vld[r.link]  = 1'b1;
    frm_data[r.link] = r.payload;
    // Odd parity over payload and parity bit
    frm_par[r.link]  = r.par_good ? ~^r.payload : ^r.payload;
    frm_seq[r.link]  = exp_tags[r.link] + r.offset;
    pkt_rdy[r.link]  = r.rdy;
    row_kind         = r.kind;
    @(negedge CLK_IN);
    frm_vld = '0;
    end_test(i + 1);
  endtask

  task automatic read_counters(int n);
    rd_en = 1'b1;
    for (int a = 0; a < 64; a++)
    begin
      ctr_addr = ctr_addr_t'(a);
      @(negedge CLK_IN);
    end
    rd_en = 1'b0;
    end_test(n);
  endtask

  initial
  begin
    CLK_IN = 1'b0;
    forever #2 CLK_IN = ~CLK_IN;
  end

  // Run limit
  always @(posedge CLK_IN)
  begin
    cycles++;
    if (cycles > max_cycles)
    begin
      $display("Run stopped, no finish within %0d cycles", max_cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'h936a));
    RESET_IN = 1'b1;
    frm_vld  = '0;
    frm_data = '0;
    frm_par  = '0;
    frm_seq  = '0;
    pkt_rdy  = '1;
    ctr_addr = '0;
    rd_en    = 1'b0;
    row_kind = 2'd3;
    test_end = 1'b0;
    test_num = 0;
    report   = 1'b0;
    load_table();
    repeat (2) @(posedge CLK_IN);
    @(negedge CLK_IN);
    RESET_IN = 1'b0;
    // Counters read zero right after reset
    read_counters(0);
    for (int i = 0; i < num_rows; i++)
      apply_row(i);
    // Drain all held packets, then read every address
    pkt_rdy = '1;
    while (pkt_vld != '0)
      @(negedge CLK_IN);
    read_counters(num_rows + 1);
    report = 1'b1;
    @(negedge CLK_IN);
    report = 1'b0;
    if (total_assert_fails() != 0)
      $display("%0d assertion failures in the frame checkers", total_assert_fails());
    if (err_cnt == 0 && total_assert_fails() == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/spio_link_test_pkg.sv
verilog/spio_frame_checker.sv
verilog/spio_packet_counter.sv
verilog/spio_link_test_top.sv
test/spio_link_test_checker.sv
test/spio_link_test_asserts.sv
test/spio_link_test_tb.sv
